// ==== rtl/mcpu_pkg.sv ====
package mcpu_pkg;

  typedef logic [15:0] cpu_addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [26:0] dl_addr_t;
  typedef logic [10:0] scroll_t;

  // main cpu memory map, upper bounds of each region
  localparam cpu_addr_t ROM1_END = 16'h8000;
  localparam cpu_addr_t ROM2_END = 16'hc000;
  localparam cpu_addr_t BANK_END = 16'he000;
  localparam cpu_addr_t SPR_END  = 16'he100;

  // download stream layout
  localparam dl_addr_t DL_ROM2_BASE  = 27'h0008000;
  localparam dl_addr_t DL_BANK1_BASE = 27'h000c000;
  localparam dl_addr_t DL_BANK2_BASE = 27'h000e000;
  localparam dl_addr_t DL_END        = 27'h0010000;

  localparam byte_t PORT_J1         = 8'h00;
  localparam byte_t PORT_J2         = 8'h01;
  localparam byte_t PORT_SYSTEM     = 8'h02;
  localparam byte_t PORT_P1         = 8'h03;
  localparam byte_t PORT_P2         = 8'h04;
  localparam byte_t PORT_BANK       = 8'h40;
  localparam byte_t PORT_SCROLLX_LO = 8'h41;
  localparam byte_t PORT_SCROLLX_HI = 8'h42;
  localparam byte_t PORT_SCROLLY_LO = 8'h43;
  localparam byte_t PORT_SCROLLY_HI = 8'h44;
  localparam byte_t PORT_SND_LATCH  = 8'h45;
  localparam byte_t PORT_ID         = 8'hc0;

  localparam byte_t BOARD_ID = 8'h58;

  localparam int ROM1_AW = 15;
  localparam int ROM2_AW = 14;
  localparam int BANK_AW = 13;
  localparam int SPR_AW  = 8;
  localparam int RAM_AW  = 13;

  typedef struct packed {
    cpu_addr_t addr;
    byte_t     dout;
    logic      rd_n;
    logic      wr_n;
    logic      iorq_n;
    logic      m1_n;
  } cpu_bus_t;

  typedef struct packed {
    logic     download;
    dl_addr_t addr;
    byte_t    data;
    logic     wr;
  } dl_bus_t;

  typedef struct packed {
    logic io;
    logic rom1;
    logic rom2;
    logic bank;
    logic spr;
    logic ram;
  } mem_sel_t;

  typedef struct packed {
    logic rom1;
    logic rom2;
    logic bank1;
    logic bank2;
  } dl_sel_t;

  typedef struct packed {
    byte_t rom1;
    byte_t rom2;
    byte_t bank;
    byte_t spr;
    byte_t ram;
  } mem_q_t;

  typedef struct packed {
    scroll_t    scrollx;
    scroll_t    scrolly;
    logic [2:0] layers;
    logic       flip;
  } video_ctrl_t;

  typedef struct packed {
    byte_t j1;
    byte_t j2;
    byte_t system;
    byte_t p1;
    byte_t p2;
  } player_in_t;

endpackage

// ==== rtl/mcpu_addr_decode.sv ====
`timescale 1ns/1ps

module mcpu_addr_decode
  import mcpu_pkg::*;
(
  input  cpu_bus_t cpu,
  input  dl_bus_t  dl,
  output mem_sel_t sel,
  output dl_sel_t  dl_sel
);

  // cpu side, io cycles take priority over the memory map
  always_comb begin
    sel = '0;
    if (!cpu.iorq_n) begin
      sel.io = 1'b1;
    end else if (cpu.addr < ROM1_END) begin
      sel.rom1 = 1'b1;
    end else if (cpu.addr < ROM2_END) begin
      sel.rom2 = 1'b1;
    end else if (cpu.addr < BANK_END) begin
      sel.bank = 1'b1;
    end else if (cpu.addr < SPR_END) begin
      sel.spr = 1'b1;
    end else begin
      sel.ram = 1'b1;
    end
  end

  // loader side, nothing selected outside a download
  always_comb begin
    dl_sel = '0;
    if (dl.download) begin
      if (dl.addr < DL_ROM2_BASE) begin
        dl_sel.rom1 = 1'b1;
      end else if (dl.addr < DL_BANK1_BASE) begin
        dl_sel.rom2 = 1'b1;
      end else if (dl.addr < DL_BANK2_BASE) begin
        dl_sel.bank1 = 1'b1;
      end else if (dl.addr < DL_END) begin
        dl_sel.bank2 = 1'b1;
      end
    end
  end

  always_comb begin
    sel_onehot_a : assert final ($onehot(sel))
      else $error("region select not one-hot: %b", sel);
    dl_sel_onehot_a : assert final ($onehot0(dl_sel))
      else $error("download target not one-hot: %b", dl_sel);
  end

endmodule

// ==== rtl/mcpu_memories.sv ====
`timescale 1ns/1ps

module mcpu_memories
  import mcpu_pkg::*;
(
  input  logic     clk_sys,
  input  cpu_bus_t cpu,
  input  dl_bus_t  dl,
  input  mem_sel_t sel,
  input  dl_sel_t  dl_sel,
  input  logic     bank,
  output mem_q_t   q
);

  byte_t rom1_mem  [2**ROM1_AW];
  byte_t rom2_mem  [2**ROM2_AW];
  byte_t bank1_mem [2**BANK_AW];
  byte_t bank2_mem [2**BANK_AW];
  byte_t spr_mem   [2**SPR_AW];
  byte_t ram_mem   [2**RAM_AW];

  dl_addr_t rom2_off;
  dl_addr_t bank1_off;
  dl_addr_t bank2_off;

  logic [ROM1_AW-1:0] rom1_addr;
  logic [ROM2_AW-1:0] rom2_addr;
  logic [BANK_AW-1:0] bank1_addr;
  logic [BANK_AW-1:0] bank2_addr;

  logic spr_we;
  logic ram_we;

  byte_t rom1_q;
  byte_t rom2_q;
  byte_t bank1_q;
  byte_t bank2_q;
  byte_t spr_q;
  byte_t ram_q;

  // offsets inside each download window
  assign rom2_off  = dl.addr - DL_ROM2_BASE;
  assign bank1_off = dl.addr - DL_BANK1_BASE;
  assign bank2_off = dl.addr - DL_BANK2_BASE;

  assign rom1_addr  = dl.download ? dl.addr[ROM1_AW-1:0] : cpu.addr[ROM1_AW-1:0];
  assign rom2_addr  = dl.download ? rom2_off[ROM2_AW-1:0] : cpu.addr[ROM2_AW-1:0];
  assign bank1_addr = dl.download ? bank1_off[BANK_AW-1:0] : cpu.addr[BANK_AW-1:0];
  assign bank2_addr = dl.download ? bank2_off[BANK_AW-1:0] : cpu.addr[BANK_AW-1:0];

  assign spr_we = !cpu.wr_n && sel.spr;
  assign ram_we = !cpu.wr_n && sel.ram;

  always_ff @(posedge clk_sys) begin
    if (dl_sel.rom1 && dl.wr) rom1_mem[rom1_addr] <= dl.data;
    if (dl_sel.rom2 && dl.wr) rom2_mem[rom2_addr] <= dl.data;
    if (dl_sel.bank1 && dl.wr) bank1_mem[bank1_addr] <= dl.data;
    if (dl_sel.bank2 && dl.wr) bank2_mem[bank2_addr] <= dl.data;
    rom1_q  <= rom1_mem[rom1_addr];
    rom2_q  <= rom2_mem[rom2_addr];
    bank1_q <= bank1_mem[bank1_addr];
    bank2_q <= bank2_mem[bank2_addr];
  end

  // ram at e100-ffff, low 13 bits only
  always_ff @(posedge clk_sys) begin
    if (spr_we) spr_mem[cpu.addr[SPR_AW-1:0]] <= cpu.dout;
    if (ram_we) ram_mem[cpu.addr[RAM_AW-1:0]] <= cpu.dout;
    spr_q <= spr_mem[cpu.addr[SPR_AW-1:0]];
    ram_q <= ram_mem[cpu.addr[RAM_AW-1:0]];
  end

  assign q.rom1 = rom1_q;
  assign q.rom2 = rom2_q;
  assign q.bank = bank ? bank2_q : bank1_q;
  assign q.spr  = spr_q;
  assign q.ram  = ram_q;

  // the cpu is held off the bus while the loader runs
  no_wr_during_dl_a : assert property (@(posedge clk_sys) dl.download |-> !(spr_we || ram_we))
    else $error("cpu memory write during download");

endmodule

// ==== rtl/mcpu_io_ports.sv ====
`timescale 1ns/1ps

module mcpu_io_ports
  import mcpu_pkg::*;
(
  input  logic        clk_sys,
  input  logic        rst_n,
  input  cpu_bus_t    cpu,
  input  player_in_t  player,
  input  logic        vs,
  input  logic        snd_clear,
  output byte_t       io_data,
  output logic        bank,
  output video_ctrl_t video,
  output byte_t       snd_latch,
  output logic        int_n
);

  logic io_cycle;
  logic io_wr;
  logic int_ack;
  logic vs_q;

  assign io_cycle = !cpu.iorq_n && cpu.m1_n;
  assign io_wr    = io_cycle && !cpu.wr_n;
  assign int_ack  = !cpu.iorq_n && !cpu.m1_n;

  // read side, latched on every io cycle
  always_ff @(posedge clk_sys) begin
    if (io_cycle) begin
      case (cpu.addr[7:0])
        PORT_J1:     io_data <= player.j1;
        PORT_J2:     io_data <= player.j2;
        PORT_SYSTEM: io_data <= player.system;
        PORT_P1:     io_data <= player.p1;
        PORT_P2:     io_data <= player.p2;
        PORT_ID:     io_data <= BOARD_ID;
        default:     io_data <= io_data;
      endcase
    end
  end

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      bank      <= 1'b0;
      video     <= '0;
      snd_latch <= '0;
    end else begin
      // clear first so a same-cycle latch write wins
      if (snd_clear) snd_latch <= '0;
      if (io_wr) begin
        case (cpu.addr[7:0])
          PORT_BANK: begin
            bank       <= cpu.dout[7];
            video.flip <= cpu.dout[2];
          end
          PORT_SCROLLX_LO: video.scrollx[7:0] <= cpu.dout;
          PORT_SCROLLX_HI: begin
            video.layers        <= cpu.dout[7:5];
            video.scrollx[10:8] <= cpu.dout[2:0];
          end
          PORT_SCROLLY_LO: video.scrolly[7:0]  <= cpu.dout;
          PORT_SCROLLY_HI: video.scrolly[10:8] <= cpu.dout[2:0];
          PORT_SND_LATCH:  snd_latch <= {cpu.dout[6:0], 1'b1};
          default: ;
        endcase
      end
    end
  end

  // vblank irq, set on falling vs, released by acknowledge
  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      vs_q  <= 1'b0;
      int_n <= 1'b1;
    end else begin
      vs_q <= vs;
      if (vs_q && !vs) int_n <= 1'b0;
      if (int_ack) int_n <= 1'b1;
    end
  end

  ack_release_a : assert property (@(posedge clk_sys) disable iff (!rst_n) int_ack |=> int_n)
    else $error("int_n still low after acknowledge");

endmodule

// ==== rtl/mcpu_data_bus.sv ====
`timescale 1ns/1ps

module mcpu_data_bus
  import mcpu_pkg::*;
(
  input  logic     clk_sys,
  input  logic     rst_n,
  input  cpu_bus_t cpu,
  input  mem_sel_t sel,
  input  mem_q_t   q,
  input  byte_t    io_data,
  output byte_t    cpu_din
);

  byte_t rd_mux;

  always_comb begin
    if (sel.io) begin
      rd_mux = io_data;
    end else if (sel.rom1) begin
      rd_mux = q.rom1;
    end else if (sel.rom2) begin
      rd_mux = q.rom2;
    end else if (sel.bank) begin
      rd_mux = q.bank;
    end else if (sel.spr) begin
      rd_mux = q.spr;
    end else begin
      rd_mux = q.ram;
    end
  end

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      cpu_din <= '0;
    end else if (!cpu.rd_n) begin
      cpu_din <= rd_mux;
    end
  end

  // cpu sees a held byte between reads
  din_hold_a : assert property (@(posedge clk_sys) disable iff (!rst_n)
    cpu.rd_n |=> $stable(cpu_din))
    else $error("cpu_din changed without a read");

endmodule

// ==== rtl/mcpu_bus.sv ====
`timescale 1ns/1ps

module mcpu_bus
  import mcpu_pkg::*;
(
  input  logic        clk_sys,
  input  logic        rst_n,
  input  cpu_bus_t    cpu,
  input  dl_bus_t     dl,
  input  player_in_t  player,
  input  logic        vs,
  input  logic        snd_clear,
  output byte_t       cpu_din,
  output logic        int_n,
  output video_ctrl_t video,
  output byte_t       snd_latch
);

  mem_sel_t sel;
  dl_sel_t  dl_sel;
  mem_q_t   q;
  byte_t    io_data;
  logic     bank;

  mcpu_addr_decode addr_decode_i (
    .cpu    (cpu),
    .dl     (dl),
    .sel    (sel),
    .dl_sel (dl_sel)
  );

  mcpu_memories memories_i (
    .clk_sys (clk_sys),
    .cpu     (cpu),
    .dl      (dl),
    .sel     (sel),
    .dl_sel  (dl_sel),
    .bank    (bank),
    .q       (q)
  );

  mcpu_io_ports io_ports_i (
    .clk_sys   (clk_sys),
    .rst_n     (rst_n),
    .cpu       (cpu),
    .player    (player),
    .vs        (vs),
    .snd_clear (snd_clear),
    .io_data   (io_data),
    .bank      (bank),
    .video     (video),
    .snd_latch (snd_latch),
    .int_n     (int_n)
  );

  mcpu_data_bus data_bus_i (
    .clk_sys (clk_sys),
    .rst_n   (rst_n),
    .cpu     (cpu),
    .sel     (sel),
    .q       (q),
    .io_data (io_data),
    .cpu_din (cpu_din)
  );

endmodule

// ==== testbench/tb_mcpu_tasks.svh ====
`ifndef TB_MCPU_TASKS_SVH
`define TB_MCPU_TASKS_SVH

// one byte per clock, stream address is the byte index
task automatic download_range(input int first, input int last);
  int i;
  @(posedge clk_sys);
  #2;
  dl.download = 1'b1;
  for (i = first; i < last; i++) begin
    dl.addr = dl_addr_t'(i);
    dl.data = dl_pattern(i[15:0]);
    dl.wr   = 1'b1;
    @(posedge clk_sys);
    #2;
  end
  dl = '0;
endtask

task automatic mem_write(input cpu_addr_t addr, input byte_t data);
  @(posedge clk_sys);
  #2;
  cpu.addr = addr;
  cpu.dout = data;
  cpu.wr_n = 1'b0;
  @(posedge clk_sys);
  #2;
  cpu.wr_n = 1'b1;
  if (!ram_shadow.exists(addr)) wr_addrs.push_back(addr);
  ram_shadow[addr] = data;
endtask

// address held for 3 cycles
task automatic mem_read(input cpu_addr_t addr, input byte_t expected);
  @(posedge clk_sys);
  #2;
  exp_din  = expected;
  cpu.addr = addr;
  cpu.rd_n = 1'b0;
  repeat (3) @(posedge clk_sys);
  #2;
  cpu.rd_n = 1'b1;
endtask

task automatic io_write(input byte_t port, input byte_t data);
  @(posedge clk_sys);
  #2;
  cpu.addr   = {8'h00, port};
  cpu.dout   = data;
  cpu.iorq_n = 1'b0;
  cpu.wr_n   = 1'b0;
  @(posedge clk_sys);
  #2;
  cpu.iorq_n = 1'b1;
  cpu.wr_n   = 1'b1;
  case (port)
    PORT_BANK: begin
      exp_bank       = data[7];
      exp_video.flip = data[2];
    end
    PORT_SCROLLX_LO: exp_video.scrollx[7:0] = data;
    PORT_SCROLLX_HI: begin
      exp_video.scrollx[10:8] = data[2:0];
      exp_video.layers        = data[7:5];
    end
    PORT_SCROLLY_LO: exp_video.scrolly[7:0]  = data;
    PORT_SCROLLY_HI: exp_video.scrolly[10:8] = data[2:0];
    PORT_SND_LATCH:  exp_snd = {data[6:0], 1'b1};
    default: ;
  endcase
endtask

task automatic io_read(input byte_t port, input byte_t expected);
  @(posedge clk_sys);
  #2;
  exp_din    = expected;
  cpu.addr   = {8'h00, port};
  cpu.iorq_n = 1'b0;
  cpu.rd_n   = 1'b0;
  repeat (3) @(posedge clk_sys);
  #2;
  cpu.iorq_n = 1'b1;
  cpu.rd_n   = 1'b1;
endtask

task automatic int_ack_cycle();
  @(posedge clk_sys);
  #2;
  cpu.iorq_n = 1'b0;
  cpu.m1_n   = 1'b0;
  @(posedge clk_sys);
  #2;
  cpu.iorq_n = 1'b1;
  cpu.m1_n   = 1'b1;
  exp_int_n  = 1'b1;
endtask

// falling vs sets the vblank irq
task automatic vs_pulse();
  @(posedge clk_sys);
  #2;
  vs = 1'b1;
  @(posedge clk_sys);
  #2;
  vs = 1'b0;
  @(posedge clk_sys);
  #2;
  exp_int_n = 1'b0;
endtask

task automatic snd_clear_pulse();
  @(posedge clk_sys);
  #2;
  snd_clear = 1'b1;
  @(posedge clk_sys);
  #2;
  snd_clear = 1'b0;
  exp_snd   = '0;
endtask

`endif

// ==== testbench/tb_mcpu_bus.sv ====
`timescale 1ns/1ps

module tb_mcpu_bus
  import mcpu_pkg::*;
();

  localparam int     CLK_PERIOD  = 20;
  localparam int     DL_LEN      = 32'h10000;
  localparam int     TEST_CYCLES = 4000;
  localparam longint WATCHDOG_NS = longint'(DL_LEN + TEST_CYCLES) * 2 * CLK_PERIOD;

  logic        clk_sys = 1'b0;
  logic        rst_n;
  cpu_bus_t    cpu;
  dl_bus_t     dl;
  player_in_t  player;
  logic        vs;
  logic        snd_clear;
  byte_t       cpu_din;
  logic        int_n;
  video_ctrl_t video;
  byte_t       snd_latch;

  // reference model of the written state
  byte_t       exp_din;
  video_ctrl_t exp_video;
  byte_t       exp_snd;
  logic        exp_int_n;
  logic        exp_bank;
  byte_t       ram_shadow [cpu_addr_t];
  cpu_addr_t   wr_addrs [$];

  always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

  mcpu_bus mcpu_bus_i (
    .clk_sys   (clk_sys),
    .rst_n     (rst_n),
    .cpu       (cpu),
    .dl        (dl),
    .player    (player),
    .vs        (vs),
    .snd_clear (snd_clear),
    .cpu_din   (cpu_din),
    .int_n     (int_n),
    .video     (video),
    .snd_latch (snd_latch)
  );

  // downloaded byte is low address byte xor high address byte
  function automatic byte_t dl_pattern(input logic [15:0] a);
    return a[7:0] ^ a[15:8];
  endfunction

  task automatic report_mismatch(input string what);
    $display("ERR %0t: %s", $time, what);
    $display("STATUS: FAIL");
    $fatal(1, "check failed");
  endtask

  `include "tb_mcpu_tasks.svh"

  // checked on the third edge of each read
  din_a : assert property (@(posedge clk_sys) disable iff (!rst_n)
    $fell(cpu.rd_n) |-> ##2 (cpu_din == exp_din))
    else report_mismatch($sformatf("cpu_din %h at addr %h, expected %h",
                                   cpu_din, cpu.addr, exp_din));
  video_a : assert property (@(posedge clk_sys) disable iff (!rst_n)
    $fell(cpu.rd_n) |-> ##2 (video == exp_video))
    else report_mismatch($sformatf("video %h, expected %h", video, exp_video));
  snd_a : assert property (@(posedge clk_sys) disable iff (!rst_n)
    $fell(cpu.rd_n) |-> ##2 (snd_latch == exp_snd))
    else report_mismatch($sformatf("snd_latch %h, expected %h", snd_latch, exp_snd));
  int_a : assert property (@(posedge clk_sys) disable iff (!rst_n)
    $fell(cpu.rd_n) |-> ##2 (int_n == exp_int_n))
    else report_mismatch($sformatf("int_n %b, expected %b", int_n, exp_int_n));

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: test sequence did not finish within %0d ns", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int n;
    cpu_addr_t a;
    void'($urandom(32'h49f0));
    cpu = '{addr: '0, dout: '0, rd_n: 1'b1, wr_n: 1'b1, iorq_n: 1'b1, m1_n: 1'b1};
    dl        = '0;
    player    = '0;
    vs        = 1'b0;
    snd_clear = 1'b0;
    exp_din   = '0;
    exp_video = '0;
    exp_snd   = '0;
    exp_int_n = 1'b1;
    exp_bank  = 1'b0;
    rst_n     = 1'b0;
    repeat (4) @(posedge clk_sys);
    #2;
    rst_n = 1'b1;
    player.j1     = byte_t'($urandom());
    player.j2     = byte_t'($urandom());
    player.system = byte_t'($urandom());
    player.p1     = byte_t'($urandom());
    player.p2     = byte_t'($urandom());

    download_range(0, DL_LEN);
    for (n = 0; n < 'hc000; n += 'h53) begin
      mem_read(cpu_addr_t'(n), dl_pattern(cpu_addr_t'(n)));
    end
    mem_read(16'h7fff, dl_pattern(16'h7fff));
    mem_read(16'h8000, dl_pattern(16'h8000));
    mem_read(16'hbfff, dl_pattern(16'hbfff));

    // bank2 window first and then bank1 with the other bits set
    io_write(PORT_BANK, 8'h84);
    for (n = 0; n < 'h2000; n += 'h80) begin
      a = (exp_bank ? 16'he000 : 16'hc000) + cpu_addr_t'(n);
      mem_read(cpu_addr_t'('hc000 + n), dl_pattern(a));
    end
    io_write(PORT_BANK, 8'h7b);
    for (n = 0; n < 'h2000; n += 'h80) begin
      a = (exp_bank ? 16'he000 : 16'hc000) + cpu_addr_t'(n);
      mem_read(cpu_addr_t'('hc000 + n), dl_pattern(a));
    end

    for (n = 0; n < 32; n++) begin
      a = 16'he000 | cpu_addr_t'($urandom_range(0, 255));
      mem_write(a, byte_t'($urandom()));
      a = cpu_addr_t'($urandom_range(16'he100, 16'hffff));
      mem_write(a, byte_t'($urandom()));
    end
    foreach (wr_addrs[k]) begin
      mem_read(wr_addrs[k], ram_shadow[wr_addrs[k]]);
    end

    io_read(PORT_J1, player.j1);
    io_read(PORT_J2, player.j2);
    io_read(PORT_SYSTEM, player.system);
    io_read(PORT_P1, player.p1);
    io_read(PORT_P2, player.p2);
    io_read(PORT_ID, 8'h58);
    io_write(PORT_SCROLLX_LO, byte_t'($urandom()));
    io_write(PORT_SCROLLX_HI, byte_t'($urandom()));
    io_write(PORT_SCROLLY_LO, byte_t'($urandom()));
    io_write(PORT_SCROLLY_HI, byte_t'($urandom()));
    io_read(PORT_ID, 8'h58);

    io_write(PORT_SND_LATCH, byte_t'($urandom()));
    io_read(PORT_J1, player.j1);
    snd_clear_pulse();
    io_read(PORT_J1, player.j1);

    vs_pulse();
    mem_read(16'h0123, dl_pattern(16'h0123));
    int_ack_cycle();
    mem_read(16'h0123, dl_pattern(16'h0123));

    repeat (4) @(posedge clk_sys);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== mcpu_bus.f ====
+incdir+testbench
rtl/mcpu_pkg.sv
rtl/mcpu_addr_decode.sv
rtl/mcpu_memories.sv
rtl/mcpu_io_ports.sv
rtl/mcpu_data_bus.sv
rtl/mcpu_bus.sv
testbench/tb_mcpu_bus.sv

// ==== Bender.yml ====
package:
  name: mcpu_bus

sources:
  - rtl/mcpu_pkg.sv
  - rtl/mcpu_addr_decode.sv
  - rtl/mcpu_memories.sv
  - rtl/mcpu_io_ports.sv
  - rtl/mcpu_data_bus.sv
  - rtl/mcpu_bus.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_mcpu_bus.sv
